//--- source/bus_pkg.sv
/*
 * Bus protocol types for the external peripheral subsystem
 * Register bus with valid/ready strobes and OBI-style memory bus
 */
`default_nettype none

package bus_pkg;

  // Register bus request
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        valid;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
    logic        ready;
  } reg_rsp_t;

  // Memory bus with req/gnt then rvalid
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

endpackage

`default_nettype wire

//--- source/ext_map_pkg.sv
/*
 * Address map of the external register peripherals
 * Port indices, address rules and register offsets
 */
`default_nettype none

package ext_map_pkg;

  localparam int unsigned EXT_NPERIPHERALS = 2;
  localparam int unsigned EXT_SEL_WIDTH = 1;

  localparam int unsigned GPIO_CNT_IDX = 0;
  localparam int unsigned POWER_CTRL_IDX = 1;

  // End address is exclusive
  typedef struct packed {
    logic [EXT_SEL_WIDTH-1:0] idx;
    logic [31:0]              start_addr;
    logic [31:0]              end_addr;
  } addr_rule_t;

  localparam addr_rule_t EXT_ADDR_RULES [EXT_NPERIPHERALS] = '{
    '{idx: EXT_SEL_WIDTH'(GPIO_CNT_IDX), start_addr: 32'h0000_0000, end_addr: 32'h0000_1000},
    '{idx: EXT_SEL_WIDTH'(POWER_CTRL_IDX), start_addr: 32'h0000_1000, end_addr: 32'h0000_2000}
  };

  // Edge counter registers decoded on addr[3:2]
  localparam logic [3:0] CNT_CTRL_OFS = 4'h0;
  localparam logic [3:0] CNT_MAX_OFS = 4'h4;
  localparam logic [3:0] CNT_VALUE_OFS = 4'h8;

  // Power controller registers
  localparam logic [3:0] PWR_SWITCH_OFS = 4'h0;
  localparam logic [3:0] PWR_STATUS_OFS = 4'h4;

endpackage

`default_nettype wire

//--- source/ext_addr_decode.sv
/*
 * Address decoder for the external register bus
 * Maps an address to a peripheral port index or flags a miss
 */
`default_nettype none

module ext_addr_decode
  import ext_map_pkg::*;
(
  input  logic [31:0]              addr_i,
  output logic [EXT_SEL_WIDTH-1:0] sel_idx_o,
  output logic                     dec_miss_o
);

  always_comb begin
    sel_idx_o = '0;
    dec_miss_o = 1'b1;
    for (int unsigned i = 0; i < EXT_NPERIPHERALS; i++) begin
      if (addr_i >= EXT_ADDR_RULES[i].start_addr && addr_i < EXT_ADDR_RULES[i].end_addr) begin
        sel_idx_o = EXT_ADDR_RULES[i].idx;
        dec_miss_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/reg_demux.sv
/*
 * Register bus demultiplexer
 * Steers a request to one peripheral and answers decode misses itself
 */
`default_nettype none

module reg_demux
  import bus_pkg::*;
  import ext_map_pkg::*;
(
  input  logic [EXT_SEL_WIDTH-1:0]        sel_idx_i,
  input  logic                            dec_miss_i,
  input  reg_req_t                        in_req_i,
  output reg_rsp_t                        in_rsp_o,
  output reg_req_t [EXT_NPERIPHERALS-1:0] out_req_o,
  input  reg_rsp_t [EXT_NPERIPHERALS-1:0] out_rsp_i
);

  // Only the selected port sees valid
  always_comb begin
    for (int unsigned i = 0; i < EXT_NPERIPHERALS; i++) begin
      out_req_o[i] = in_req_i;
      out_req_o[i].valid = in_req_i.valid && !dec_miss_i && (sel_idx_i == i);
    end
  end

  always_comb begin
    if (dec_miss_i) begin
      in_rsp_o.rdata = '0;
      in_rsp_o.error = 1'b1;
      in_rsp_o.ready = 1'b1;
    end else begin
      in_rsp_o = out_rsp_i[sel_idx_i];
    end
  end

endmodule

`default_nettype wire

//--- source/gpio_cnt.sv
/*
 * GPIO edge counter
 * Counts rising pin edges and pulses the output when the count hits max
 */
`default_nettype none

module gpio_cnt
  import bus_pkg::*;
  import ext_map_pkg::*;
#(
  parameter int unsigned CNT_MAX_RESET = 2048
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     gpio_i,
  output logic     gpio_o
);

  logic        en_q;
  logic [31:0] max_q;
  logic [31:0] cnt_q;
  logic        gpio_q;
  logic        gpio_prev_q;
  logic        wr_en;
  logic [1:0]  reg_sel;
  logic        rise;
  logic        hit;

  assign reg_sel = reg_req_i.addr[3:2];
  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign rise = gpio_q & ~gpio_prev_q & en_q;
  assign hit = rise && (cnt_q + 32'd1 >= max_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q <= 1'b0;
      max_q <= 32'(CNT_MAX_RESET);
      cnt_q <= '0;
      gpio_q <= 1'b0;
      gpio_prev_q <= 1'b0;
      gpio_o <= 1'b0;
    end else begin
      gpio_q <= gpio_i;
      gpio_prev_q <= gpio_q;
      gpio_o <= hit;
      if (wr_en && reg_sel == CNT_CTRL_OFS[3:2]) begin
        en_q <= reg_req_i.wdata[0];
      end
      if (wr_en && reg_sel == CNT_MAX_OFS[3:2]) begin
        max_q <= reg_req_i.wdata;
      end
      // Software clear wins over a counted edge
      if (wr_en && reg_sel == CNT_CTRL_OFS[3:2] && reg_req_i.wdata[1]) begin
        cnt_q <= '0;
      end else if (hit) begin
        cnt_q <= '0;
      end else if (rise) begin
        cnt_q <= cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (reg_sel)
      CNT_CTRL_OFS[3:2]:  reg_rsp_o.rdata = {31'd0, en_q};
      CNT_MAX_OFS[3:2]:   reg_rsp_o.rdata = max_q;
      CNT_VALUE_OFS[3:2]: reg_rsp_o.rdata = cnt_q;
      default:            reg_rsp_o.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/power_ctrl.sv
/*
 * Power domain controller
 * Drives switch, isolation and reset per domain from a switch register
 */
`default_nettype none

module power_ctrl
  import bus_pkg::*;
  import ext_map_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  reg_req_t               reg_req_i,
  output reg_rsp_t               reg_rsp_o,
  input  logic [NUM_DOMAINS-1:0] pg_ack_i,
  output logic [NUM_DOMAINS-1:0] pg_switch_o,
  output logic [NUM_DOMAINS-1:0] pg_iso_o,
  output logic [NUM_DOMAINS-1:0] pg_rst_n_o
);

  typedef enum logic [1:0] {
    PD_OFF,
    PD_WAIT_ACK,
    PD_ON
  } pd_state_e;

  pd_state_e [NUM_DOMAINS-1:0] state_q;
  logic [NUM_DOMAINS-1:0]      sw_q;
  logic                        wr_en;
  logic [1:0]                  reg_sel;

  assign reg_sel = reg_req_i.addr[3:2];
  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sw_q <= '0;
      pg_switch_o <= '0;
      for (int unsigned d = 0; d < NUM_DOMAINS; d++) begin
        state_q[d] <= PD_OFF;
      end
    end else begin
      if (wr_en && reg_sel == PWR_SWITCH_OFS[3:2]) begin
        sw_q <= reg_req_i.wdata[NUM_DOMAINS-1:0];
      end
      pg_switch_o <= sw_q;
      // Sequencer steps on the same edge the switch output moves
      for (int unsigned d = 0; d < NUM_DOMAINS; d++) begin
        case (state_q[d])
          PD_OFF: if (sw_q[d]) state_q[d] <= PD_WAIT_ACK;
          PD_WAIT_ACK: begin
            if (!sw_q[d]) begin
              state_q[d] <= PD_OFF;
            end else if (pg_ack_i[d]) begin
              state_q[d] <= PD_ON;
            end
          end
          PD_ON: if (!sw_q[d]) state_q[d] <= PD_OFF;
          default: state_q[d] <= PD_OFF;
        endcase
      end
    end
  end

  always_comb begin
    for (int unsigned d = 0; d < NUM_DOMAINS; d++) begin
      pg_iso_o[d] = (state_q[d] != PD_ON);
      pg_rst_n_o[d] = (state_q[d] == PD_ON);
    end
  end

  // Status has acks from bit 0 and isolation from bit 16
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (reg_sel == PWR_SWITCH_OFS[3:2]) begin
      reg_rsp_o.rdata[NUM_DOMAINS-1:0] = sw_q;
    end else if (reg_sel == PWR_STATUS_OFS[3:2]) begin
      reg_rsp_o.rdata[NUM_DOMAINS-1:0] = pg_ack_i;
      reg_rsp_o.rdata[16+:NUM_DOMAINS] = pg_iso_o;
    end
  end

endmodule

`default_nettype wire

//--- source/power_switch_model.sv
/*
 * Power switch cell model
 * Returns each domain's switch state as an acknowledge a fixed delay later
 */
`default_nettype none

module power_switch_model #(
  parameter int unsigned NUM_DOMAINS = 2,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_i,
  output logic [NUM_DOMAINS-1:0] ack_o
);

  logic [NUM_DOMAINS-1:0] chain_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= '0;
      end
    end else begin
      chain_q[0] <= switch_i;
      for (int unsigned i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign ack_o = chain_q[SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

//--- source/slow_memory.sv
/*
 * Slow word memory on an OBI-style port
 * One access at a time, response after a fixed latency
 */
`default_nettype none

module slow_memory
  import bus_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 128,
  parameter int unsigned MEM_LATENCY = 3
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o
);

  localparam int unsigned AW = $clog2(MEM_WORDS);
  localparam int unsigned CW = $clog2(MEM_LATENCY + 1);

  logic [31:0]   mem_q [MEM_WORDS];
  logic [AW-1:0] word_idx;
  logic          gnt;
  logic          busy_q;
  logic [CW-1:0] cnt_q;
  logic          rvalid_q;
  logic [31:0]   rdata_q;

  assign word_idx = obi_req_i.addr[AW+1:2];
  assign gnt = obi_req_i.req & ~busy_q;

  // Array and read data are sampled at grant
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (obi_req_i.we) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (obi_req_i.be[b]) begin
            mem_q[word_idx][8*b+:8] <= obi_req_i.wdata[8*b+:8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (gnt) begin
        busy_q <= 1'b1;
        cnt_q <= CW'(MEM_LATENCY - 1);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q <= 1'b0;
          rvalid_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  assign obi_resp_o.gnt = gnt;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/ext_periph_subsys.sv
/*
 * External peripheral subsystem
 * Register peripherals behind a decoder and demux, power switch model, slow memory
 */
`default_nettype none

module ext_periph_subsys
  import bus_pkg::*;
  import ext_map_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 2,
  parameter int unsigned SWITCH_ACK_LATENCY = 15,
  parameter int unsigned MEM_WORDS = 128,
  parameter int unsigned MEM_LATENCY = 3,
  parameter int unsigned CNT_MAX_RESET = 2048
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  reg_req_t               reg_req_i,
  output reg_rsp_t               reg_rsp_o,
  input  obi_req_t               obi_req_i,
  output obi_resp_t              obi_resp_o,
  input  logic                   gpio_i,
  output logic                   gpio_o,
  output logic [NUM_DOMAINS-1:0] pg_switch_o,
  output logic [NUM_DOMAINS-1:0] pg_iso_o,
  output logic [NUM_DOMAINS-1:0] pg_rst_n_o
);

  logic [EXT_SEL_WIDTH-1:0]        sel_idx;
  logic                            dec_miss;
  reg_req_t [EXT_NPERIPHERALS-1:0] periph_req;
  reg_rsp_t [EXT_NPERIPHERALS-1:0] periph_rsp;
  logic [NUM_DOMAINS-1:0]          pg_ack;

  ext_addr_decode u_ext_addr_decode (
    .addr_i    (reg_req_i.addr),
    .sel_idx_o (sel_idx),
    .dec_miss_o(dec_miss)
  );

  reg_demux u_reg_demux (
    .sel_idx_i (sel_idx),
    .dec_miss_i(dec_miss),
    .in_req_i  (reg_req_i),
    .in_rsp_o  (reg_rsp_o),
    .out_req_o (periph_req),
    .out_rsp_i (periph_rsp)
  );

  gpio_cnt #(
    .CNT_MAX_RESET(CNT_MAX_RESET)
  ) u_gpio_cnt (
    .clk_i,
    .rst_n_i,
    .reg_req_i(periph_req[GPIO_CNT_IDX]),
    .reg_rsp_o(periph_rsp[GPIO_CNT_IDX]),
    .gpio_i,
    .gpio_o
  );

  power_ctrl #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) u_power_ctrl (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (periph_req[POWER_CTRL_IDX]),
    .reg_rsp_o  (periph_rsp[POWER_CTRL_IDX]),
    .pg_ack_i   (pg_ack),
    .pg_switch_o,
    .pg_iso_o,
    .pg_rst_n_o
  );

  power_switch_model #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) u_power_switch_model (
    .clk_i,
    .rst_n_i,
    .switch_i(pg_switch_o),
    .ack_o   (pg_ack)
  );

  slow_memory #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_slow_memory (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_resp_o
  );

endmodule

`default_nettype wire

//--- tb/tb_ext_periph_subsys.sv
/*
 * Testbench for the external peripheral subsystem
 * Random register, counter, memory and power traffic checked against a model
 */
`default_nettype none

module tb_ext_periph_subsys
  import bus_pkg::*;
  import ext_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SWITCH_LAT = 15;
  localparam int MEM_LAT = 3;
  localparam logic [31:0] CNT_MAX_RST = 32'd2048;

  localparam logic [31:0] GPIO_BASE = 32'h0000_0000;
  localparam logic [31:0] PWR_BASE = 32'h0000_1000;
  localparam logic [31:0] CNT_CTRL_ADDR = GPIO_BASE + 32'(CNT_CTRL_OFS);
  localparam logic [31:0] CNT_MAX_ADDR = GPIO_BASE + 32'(CNT_MAX_OFS);
  localparam logic [31:0] CNT_VALUE_ADDR = GPIO_BASE + 32'(CNT_VALUE_OFS);
  localparam logic [31:0] PWR_SWITCH_ADDR = PWR_BASE + 32'(PWR_SWITCH_OFS);
  localparam logic [31:0] PWR_STATUS_ADDR = PWR_BASE + 32'(PWR_STATUS_OFS);
  localparam logic [31:0] UNMAPPED_ADDR [4] = '{
    32'h0000_000C, 32'h0000_0FFC, 32'h0000_1008, 32'h0000_100C
  };

  // Worst case cycles of reset and each test in order, plus a margin
  localparam int MAX_CYCLES = 10 + 90 + 40 + 170 + 130 + 110 + 100;

  logic        clk;
  logic        rst_n;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  logic        gpio_in;
  logic        gpio_out;
  logic [1:0]  pg_switch;
  logic [1:0]  pg_iso;
  logic [1:0]  pg_rst_n;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          gpio_pulses = 0;
  int          mem_rsps = 0;
  logic [31:0] lfsr_state = 32'd3;

  // Reference model state
  logic        cnt_en;
  logic [31:0] cnt_max;
  logic [1:0]  pwr_sw;
  logic [31:0] mem_model [128];
  int          grant_q[$];
  logic [31:0] data_q[$];

  ext_periph_subsys u_ext_periph_subsys (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .obi_req_i  (obi_req),
    .obi_resp_o (obi_resp),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .pg_switch_o(pg_switch),
    .pg_iso_o   (pg_iso),
    .pg_rst_n_o (pg_rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
    end
    return v;
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp_val,
                              input string msg);
    checks++;
    if (got !== exp_val) begin
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp_val);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errs);
    $display("Test %-16s done, %0d errors", name, errors - start_errs);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic reg_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #2;
    reg_req.addr = addr;
    reg_req.write = wr;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hf;
    reg_req.valid = 1'b1;
    #5;
    expect_equal(reg_rsp.ready, 1'b1, "ready in the request cycle");
    rdata = reg_rsp.rdata;
    err = reg_rsp.error;
    // Transfer completes on this edge
    @(posedge clk);
    #2;
    reg_req.valid = 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    reg_xfer(addr, 1'b1, data, rdata, err);
    expect_equal(err, exp_err, "write error flag");
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_val,
                             input logic exp_err, input string msg);
    logic [31:0] rdata;
    logic        err;
    reg_xfer(addr, 1'b0, 32'h0, rdata, err);
    expect_equal(rdata, exp_val, msg);
    expect_equal(err, exp_err, "read error flag");
  endtask

  // Holds the request until granted and returns after the granting edge
  task automatic mem_issue(input logic we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    obi_req.req = 1'b1;
    obi_req.we = we;
    obi_req.be = be;
    obi_req.addr = addr;
    obi_req.wdata = wdata;
    @(negedge clk);
    while (obi_resp.gnt !== 1'b1) @(negedge clk);
    @(posedge clk);
    #2;
    obi_req.req = 1'b0;
  endtask

  always @(negedge clk) begin
    if (gpio_out === 1'b1) gpio_pulses++;
  end

  // Memory model follows the bus at grant and checks each response
  always @(negedge clk) begin : mem_monitor
    logic [6:0] idx;
    if (obi_resp.rvalid === 1'b1) begin
      if (grant_q.size() == 0) begin
        $display("Error at %0t ns: rvalid with no access outstanding", $time);
        errors++;
      end else begin
        expect_equal(cycle, grant_q.pop_front() + 1 + MEM_LAT, "rvalid latency");
        expect_equal(obi_resp.rdata, data_q.pop_front(), "memory read data");
        mem_rsps++;
      end
    end
    if (obi_resp.gnt === 1'b1) begin
      if (grant_q.size() != 0) begin
        $display("Error at %0t ns: gnt high while an access is outstanding", $time);
        errors++;
      end
      idx = obi_req.addr[8:2];
      grant_q.push_back(cycle);
      if (obi_req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (obi_req.be[b]) mem_model[idx][8*b+:8] = obi_req.wdata[8*b+:8];
        end
        data_q.push_back(32'h0);
      end else begin
        data_q.push_back(mem_model[idx]);
      end
    end
  end

  task automatic reset_state_test();
    int start;
    start = errors;
    expect_equal(pg_switch, 2'b00, "switch after reset");
    expect_equal(pg_iso, 2'b11, "isolation after reset");
    expect_equal(pg_rst_n, 2'b00, "domain reset after reset");
    expect_equal(gpio_out, 1'b0, "gpio_o after reset");
    expect_equal(obi_resp.rvalid, 1'b0, "rvalid after reset");
    read_expect(CNT_CTRL_ADDR, 32'h0, 1'b0, "CNT_CTRL after reset");
    read_expect(CNT_MAX_ADDR, CNT_MAX_RST, 1'b0, "CNT_MAX after reset");
    read_expect(CNT_VALUE_ADDR, 32'h0, 1'b0, "CNT_VALUE after reset");
    finish_test("reset state", start);
  endtask

  task automatic reg_access_test();
    int          start;
    int          sel;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] exp_val;
    start = errors;
    for (int i = 0; i < 20; i++) begin
      sel = rand_bits(2);
      data = rand_bits(32);
      case (sel)
        0: begin
          addr = CNT_CTRL_ADDR;
          cnt_en = data[0];
          exp_val = {31'd0, data[0]};
        end
        1: begin
          addr = CNT_MAX_ADDR;
          cnt_max = data;
          exp_val = data;
        end
        2: begin
          addr = PWR_SWITCH_ADDR;
          pwr_sw = data[1:0];
          exp_val = {30'd0, data[1:0]};
        end
        default: begin
          addr = UNMAPPED_ADDR[rand_bits(2)];
          exp_val = 32'h0;
        end
      endcase
      reg_write(addr, data, 1'b0);
      read_expect(addr, exp_val, 1'b0, "register readback");
    end
    read_expect(CNT_VALUE_ADDR, 32'h0, 1'b0, "CNT_VALUE with gpio idle");
    finish_test("register access", start);
  endtask

  task automatic decode_miss_test();
    int          start;
    logic [31:0] addr;
    start = errors;
    for (int i = 0; i < 6; i++) begin
      addr = rand_bits(32) | 32'h0000_2000;
      reg_write(addr, rand_bits(32), 1'b1);
      read_expect(addr, 32'h0, 1'b1, "miss read data");
    end
    read_expect(CNT_CTRL_ADDR, {31'd0, cnt_en}, 1'b0, "CNT_CTRL after misses");
    read_expect(CNT_MAX_ADDR, cnt_max, 1'b0, "CNT_MAX after misses");
    read_expect(PWR_SWITCH_ADDR, {30'd0, pwr_sw}, 1'b0, "PWR_SWITCH after misses");
    finish_test("decode miss", start);
  endtask

  task automatic edge_count_test();
    int start;
    int max_val;
    int n;
    start = errors;
    max_val = 2 + rand_bits(3);
    n = 4 + rand_bits(5);
    reg_write(CNT_MAX_ADDR, max_val, 1'b0);
    cnt_max = max_val;
    reg_write(CNT_CTRL_ADDR, 32'h3, 1'b0);
    cnt_en = 1'b1;
    gpio_pulses = 0;
    for (int i = 0; i < n; i++) begin
      gpio_in = 1'b1;
      wait_cycles(2);
      gpio_in = 1'b0;
      wait_cycles(1 + rand_bits(1));
    end
    wait_cycles(3);
    expect_equal(gpio_pulses, n / max_val, "gpio_o pulse count");
    read_expect(CNT_VALUE_ADDR, n % max_val, 1'b0, "count remainder");
    reg_write(CNT_CTRL_ADDR, 32'h3, 1'b0);
    read_expect(CNT_VALUE_ADDR, 32'h0, 1'b0, "count after clear");
    reg_write(CNT_CTRL_ADDR, 32'h0, 1'b0);
    cnt_en = 1'b0;
    finish_test("edge counter", start);
  endtask

  task automatic memory_test();
    int          start;
    logic [31:0] addrs [8];
    start = errors;
    mem_rsps = 0;
    // Full words first so that no model byte stays unknown
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_bits(7) << 2;
      mem_issue(1'b1, addrs[i], 4'hf, rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      mem_issue(1'b1, addrs[rand_bits(3)], 4'(rand_bits(4)), rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      mem_issue(1'b0, addrs[i], 4'hf, 32'h0);
    end
    while (grant_q.size() != 0) wait_cycles(1);
    expect_equal(mem_rsps, 24, "memory response count");
    finish_test("memory", start);
  endtask

  task automatic power_seq_test();
    int         start;
    int         d;
    int         n;
    logic [1:0] on_mask;
    start = errors;
    reg_write(PWR_SWITCH_ADDR, 32'h0, 1'b0);
    pwr_sw = 2'b00;
    wait_cycles(SWITCH_LAT + 5);
    expect_equal(pg_iso, 2'b11, "isolation with all domains off");
    expect_equal(pg_rst_n, 2'b00, "domain reset with all domains off");
    for (int k = 0; k < 2; k++) begin
      d = rand_bits(1);
      on_mask = 2'b01 << d;
      reg_write(PWR_SWITCH_ADDR, {30'd0, on_mask}, 1'b0);
      n = 0;
      while (pg_iso[d] && n < SWITCH_LAT + 10) begin
        wait_cycles(1);
        n++;
      end
      expect_equal(n, SWITCH_LAT + 2, "cycles from power-up write to release");
      expect_equal(pg_rst_n, on_mask, "domain reset after power-up");
      expect_equal(pg_switch, on_mask, "switch after power-up");
      read_expect(PWR_STATUS_ADDR, {14'd0, ~on_mask, 14'd0, on_mask}, 1'b0, "power status");
      reg_write(PWR_SWITCH_ADDR, 32'h0, 1'b0);
      expect_equal(pg_iso[d], 1'b0, "isolation on the power-down edge");
      wait_cycles(1);
      expect_equal(pg_iso[d], 1'b1, "isolation after power-down");
      expect_equal(pg_rst_n[d], 1'b0, "domain reset after power-down");
      expect_equal(pg_switch, 2'b00, "switch after power-down");
      // Let the acknowledge drain before the next domain
      wait_cycles(SWITCH_LAT + 2);
    end
    finish_test("power sequence", start);
  endtask

  initial begin
    rst_n = 1'b0;
    reg_req = '0;
    obi_req = '0;
    gpio_in = 1'b0;
    cnt_en = 1'b0;
    cnt_max = CNT_MAX_RST;
    pwr_sw = 2'b00;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_state_test();
    reg_access_test();
    decode_miss_test();
    edge_count_test();
    memory_test();
    power_seq_test();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ext_periph_subsys.f
source/bus_pkg.sv
source/ext_map_pkg.sv
source/ext_addr_decode.sv
source/reg_demux.sv
source/gpio_cnt.sv
source/power_ctrl.sv
source/power_switch_model.sv
source/slow_memory.sv
source/ext_periph_subsys.sv
tb/tb_ext_periph_subsys.sv

//--- Bender.yml
package:
  name: ext_periph_subsys

sources:
  - source/bus_pkg.sv
  - source/ext_map_pkg.sv
  - source/ext_addr_decode.sv
  - source/reg_demux.sv
  - source/gpio_cnt.sv
  - source/power_ctrl.sv
  - source/power_switch_model.sv
  - source/slow_memory.sv
  - source/ext_periph_subsys.sv
  - target: test
    files:
      - tb/tb_ext_periph_subsys.sv
